/* Bender.yml */
package:
  name: dtlb

sources:
  - files:
      - hw/dtlb_pkg.sv
      - hw/tlb_ram.sv
      - hw/dtlb_ways.sv
      - hw/dtlb_ctrl.sv
      - hw/dtlb.sv
  - target: test
    files:
      - test/ptw_model.sv
      - test/tb_dtlb.sv

/* dtlb.f */
hw/dtlb_pkg.sv
hw/tlb_ram.sv
hw/dtlb_ways.sv
hw/dtlb_ctrl.sv
hw/dtlb.sv
test/ptw_model.sv
test/tb_dtlb.sv

/* hw/dtlb.sv */
`timescale 1ns/1ns

module dtlb #(
   parameter int set_bits = dtlb_pkg::default_set_bits
) (
   input  logic                    dtlb_clk,
   input  logic                    rst,
   input  dtlb_pkg::vpn_t          req_addr,
   input  logic                    req_re,
   input  dtlb_pkg::pagedir_base_t pagedir_base,
   output dtlb_pkg::ppn_t          phys_addr,
   output dtlb_pkg::flags_t        flags,
   output logic                    ready,
   output dtlb_pkg::vpn_t          ptw_addr,
   output logic                    ptw_re,
   output dtlb_pkg::pagedir_base_t ptw_pagedir_base,
   input  dtlb_pkg::ppn_t          ptw_phys_addr,
   input  dtlb_pkg::flags_t        ptw_pagetab_flags,
   input  dtlb_pkg::flags_t        ptw_pagedir_flags,
   input  logic                    ptw_ready
);

   import dtlb_pkg::*;

   logic [set_bits-1:0]          ram_set;
   logic [vpn_bits-set_bits-1:0] cmp_tag;
   logic                         hit;
   logic                         hit_way;
   logic                         evict_way;
   logic                         fill_we;
   logic                         fill_way;
   logic                         fill_valid;
   ppn_t                         fill_ppn;
   flags_t                       fill_flags;
   logic                         evict_we;
   logic                         evict_data;

   // Page directory base goes straight to the walker
   assign ptw_pagedir_base = pagedir_base;

   dtlb_ctrl #(
      .set_bits (set_bits)
   ) u_ctrl (
      .dtlb_clk          (dtlb_clk),
      .rst               (rst),
      .req_addr          (req_addr),
      .req_re            (req_re),
      .ready             (ready),
      .ptw_addr          (ptw_addr),
      .ptw_re            (ptw_re),
      .ptw_phys_addr     (ptw_phys_addr),
      .ptw_pagetab_flags (ptw_pagetab_flags),
      .ptw_pagedir_flags (ptw_pagedir_flags),
      .ptw_ready         (ptw_ready),
      .ram_set           (ram_set),
      .cmp_tag           (cmp_tag),
      .hit               (hit),
      .hit_way           (hit_way),
      .evict_way         (evict_way),
      .fill_we           (fill_we),
      .fill_way          (fill_way),
      .fill_valid        (fill_valid),
      .fill_ppn          (fill_ppn),
      .fill_flags        (fill_flags),
      .evict_we          (evict_we),
      .evict_data        (evict_data)
   );

   dtlb_ways #(
      .set_bits (set_bits)
   ) u_ways (
      .dtlb_clk   (dtlb_clk),
      .ram_set    (ram_set),
      .cmp_tag    (cmp_tag),
      .fill_we    (fill_we),
      .fill_way   (fill_way),
      .fill_valid (fill_valid),
      .fill_ppn   (fill_ppn),
      .fill_flags (fill_flags),
      .evict_we   (evict_we),
      .evict_data (evict_data),
      .hit        (hit),
      .hit_way    (hit_way),
      .evict_way  (evict_way),
      .phys_addr  (phys_addr),
      .flags      (flags)
   );

endmodule

/* hw/dtlb_ctrl.sv */
`timescale 1ns/1ns

module dtlb_ctrl #(
   parameter int set_bits = dtlb_pkg::default_set_bits
) (
   input  logic                                   dtlb_clk,
   input  logic                                   rst,
   input  dtlb_pkg::vpn_t                         req_addr,
   input  logic                                   req_re,
   output logic                                   ready,
   output dtlb_pkg::vpn_t                         ptw_addr,
   output logic                                   ptw_re,
   input  dtlb_pkg::ppn_t                         ptw_phys_addr,
   input  dtlb_pkg::flags_t                       ptw_pagetab_flags,
   input  dtlb_pkg::flags_t                       ptw_pagedir_flags,
   input  logic                                   ptw_ready,
   output logic [set_bits-1:0]                    ram_set,
   output logic [dtlb_pkg::vpn_bits-set_bits-1:0] cmp_tag,
   input  logic                                   hit,
   input  logic                                   hit_way,
   input  logic                                   evict_way,
   output logic                                   fill_we,
   output logic                                   fill_way,
   output logic                                   fill_valid,
   output dtlb_pkg::ppn_t                         fill_ppn,
   output dtlb_pkg::flags_t                       fill_flags,
   output logic                                   evict_we,
   output logic                                   evict_data
);

   import dtlb_pkg::*;

   dtlb_state_t         state;
   dtlb_state_t         next_state;
   evict_mode_t         evict_mode;

   // Latched request address
   vpn_t                addr_q;
   logic                accept;
   logic                use_imm;
   logic [set_bits-1:0] sweep_set;
   flags_t              merged_flags;

   assign ready = (state == st_idle) | ((state == st_comparing) & hit);
   assign accept = req_re & ready;

   // Tag sits above the set index
   assign cmp_tag = addr_q[vpn_bits-1:set_bits];

   always_comb begin
      next_state = state;
      evict_mode = evict_none;
      use_imm = 1'b0;

      case (state)
         st_clear: begin
            if (&sweep_set) begin
               next_state = st_idle;
            end
         end
         st_idle: begin
            use_imm = 1'b1;
            if (req_re) begin
               next_state = st_comparing;
            end
         end
         st_comparing: begin
            if (hit) begin
               evict_mode = evict_from_hit;
               // Read the next request's set so it can be compared next cycle
               use_imm = 1'b1;
               if (!req_re) begin
                  next_state = st_idle;
               end
            end else begin
               next_state = st_lookup;
            end
         end
         st_lookup: begin
            if (ptw_ready) begin
               evict_mode = evict_from_miss;
               next_state = st_idle;
            end
         end
         default: next_state = st_clear;
      endcase
   end

   // RAM set select
   always_comb begin
      if (state == st_clear) begin
         ram_set = sweep_set;
      end else if (use_imm) begin
         ram_set = req_addr[set_bits-1:0];
      end else begin
         ram_set = addr_q[set_bits-1:0];
      end
   end

   // Walker request, dropped in the cycle the answer arrives
   assign ptw_addr = addr_q;
   assign ptw_re = ((state == st_comparing) & ~hit) | ((state == st_lookup) & ~ptw_ready);

   // Present and writeable need both levels, kernel and global either one
   always_comb begin
      merged_flags[flag_present] = ptw_pagedir_flags[flag_present] &
                                   ptw_pagetab_flags[flag_present];
      merged_flags[flag_writeable] = ptw_pagedir_flags[flag_writeable] &
                                     ptw_pagetab_flags[flag_writeable];
      merged_flags[flag_kernel] = ptw_pagedir_flags[flag_kernel] |
                                  ptw_pagetab_flags[flag_kernel];
      merged_flags[flag_global] = ptw_pagedir_flags[flag_global] |
                                  ptw_pagetab_flags[flag_global];
   end

   // Fill goes to the way the eviction bit names
   assign fill_we = (state == st_clear) | (evict_mode == evict_from_miss);
   assign fill_way = evict_way;
   assign fill_valid = (state != st_clear);
   assign fill_ppn = ptw_phys_addr;
   assign fill_flags = merged_flags;

   always_comb begin
      case (evict_mode)
         evict_from_hit: begin
            // Next victim is the way that did not hit
            evict_we = 1'b1;
            evict_data = ~hit_way;
         end
         evict_from_miss: begin
            evict_we = 1'b1;
            evict_data = ~evict_way;
         end
         default: begin
            evict_we = (state == st_clear);
            evict_data = 1'b0;
         end
      endcase
   end

   always_ff @(posedge dtlb_clk) begin
      if (rst) begin
         state <= st_clear;
         sweep_set <= '0;
      end else begin
         state <= next_state;
         if (state == st_clear) begin
            sweep_set <= sweep_set + 1'b1;
         end
      end
   end

   always_ff @(posedge dtlb_clk) begin
      if (accept) begin
         addr_q <= req_addr;
      end
   end

endmodule

/* hw/dtlb_pkg.sv */
package dtlb_pkg;

   // Field widths of a translation
   localparam int vpn_bits = 20;
   localparam int ppn_bits = 20;
   localparam int pagedir_bits = 20;
   localparam int flags_bits = 4;

   // 8192 sets of two ways in the full-size TLB
   localparam int default_set_bits = 13;

   typedef logic [vpn_bits-1:0]     vpn_t;
   typedef logic [ppn_bits-1:0]     ppn_t;
   typedef logic [pagedir_bits-1:0] pagedir_base_t;
   typedef logic [flags_bits-1:0]   flags_t;

   // Bit positions inside flags_t
   localparam int flag_present = 0;
   localparam int flag_writeable = 1;
   localparam int flag_kernel = 2;
   localparam int flag_global = 3;

   // A cached entry is packed from MSB to LSB as
   //    valid bit, tag, flags, physical page
   // The tag is vpn_bits - set_bits wide, so the entry width
   // depends on the set count chosen at the top level

   // Lookup controller
   typedef enum logic [1:0] {
      st_clear,
      st_idle,
      st_comparing,
      st_lookup
   } dtlb_state_t;

   // How the eviction bit of the current set gets rewritten
   typedef enum logic [1:0] {
      evict_none,
      evict_from_hit,
      evict_from_miss
   } evict_mode_t;

endpackage

/* hw/dtlb_ways.sv */
`timescale 1ns/1ns

module dtlb_ways #(
   parameter int set_bits = dtlb_pkg::default_set_bits
) (
   input  logic                                   dtlb_clk,
   input  logic [set_bits-1:0]                    ram_set,
   input  logic [dtlb_pkg::vpn_bits-set_bits-1:0] cmp_tag,
   input  logic                                   fill_we,
   input  logic                                   fill_way,
   input  logic                                   fill_valid,
   input  dtlb_pkg::ppn_t                         fill_ppn,
   input  dtlb_pkg::flags_t                       fill_flags,
   input  logic                                   evict_we,
   input  logic                                   evict_data,
   output logic                                   hit,
   output logic                                   hit_way,
   output logic                                   evict_way,
   output dtlb_pkg::ppn_t                         phys_addr,
   output dtlb_pkg::flags_t                       flags
);

   import dtlb_pkg::*;

   localparam int tag_bits = vpn_bits - set_bits;
   localparam int entry_bits = 1 + tag_bits + flags_bits + ppn_bits;
   localparam int ways = 2;

   logic [entry_bits-1:0] wr_entry;
   logic [entry_bits-1:0] rd_entry [ways];

   // Unpacked read words
   logic                  rd_valid [ways];
   logic [tag_bits-1:0]   rd_tag [ways];
   flags_t                rd_flags [ways];
   ppn_t                  rd_ppn [ways];

   logic [ways-1:0]       way_hit;

   // Set whose words are on the RAM outputs this cycle
   logic [set_bits-1:0]   set_q;
   logic [set_bits-1:0]   evict_addr;

   // The fill tag is always the tag under comparison
   assign wr_entry = {fill_valid, cmp_tag, fill_flags, fill_ppn};

   for (genvar w = 0; w < ways; w++) begin : g_way
      logic way_we;

      // An invalidating write clears both ways of the set at once
      assign way_we = fill_we & (~fill_valid | (fill_way == 1'(w)));

      tlb_ram #(
         .data_bits (entry_bits),
         .addr_bits (set_bits)
      ) u_data (
         .clk   (dtlb_clk),
         .we    (way_we),
         .addr  (ram_set),
         .wdata (wr_entry),
         .rdata (rd_entry[w])
      );

      assign {rd_valid[w], rd_tag[w], rd_flags[w], rd_ppn[w]} = rd_entry[w];

      // Hit needs a valid entry with a matching tag
      assign way_hit[w] = rd_valid[w] & (rd_tag[w] == cmp_tag);
   end

   assign hit = |way_hit;
   assign hit_way = way_hit[1];

   // Result always comes from the RAM read data, also after a fill
   assign phys_addr = rd_ppn[hit_way];
   assign flags = rd_flags[hit_way];

   always_ff @(posedge dtlb_clk) begin
      set_q <= ram_set;
   end

   // Eviction bits follow the set being compared, so a hit can update it
   // while the data RAMs already read the next request's set.
   // Fills and the clear sweep write the set on the address bus.
   assign evict_addr = fill_we ? ram_set : set_q;

   tlb_ram #(
      .data_bits (1),
      .addr_bits (set_bits)
   ) u_evict (
      .clk   (dtlb_clk),
      .we    (evict_we),
      .addr  (evict_addr),
      .wdata (evict_data),
      .rdata (evict_way)
   );

endmodule

/* hw/tlb_ram.sv */
`timescale 1ns/1ns

module tlb_ram #(
   parameter int data_bits = 32,
   parameter int addr_bits = 13
) (
   input  logic                 clk,
   input  logic                 we,
   input  logic [addr_bits-1:0] addr,
   input  logic [data_bits-1:0] wdata,
   output logic [data_bits-1:0] rdata
);

   localparam int depth = 1 << addr_bits;

   logic [data_bits-1:0] mem [depth];

   // Registered read port; a write shows up on rdata right away
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
         rdata <= wdata;
      end else begin
         rdata <= mem[addr];
      end
   end

endmodule

/* test/ptw_model.sv */
`timescale 1ns/1ns

module ptw_model #(
   parameter int seed_init = 1
) (
   input  logic                    dtlb_clk,
   input  dtlb_pkg::vpn_t          ptw_addr,
   input  logic                    ptw_re,
   input  dtlb_pkg::pagedir_base_t ptw_pagedir_base,
   output dtlb_pkg::ppn_t          ptw_phys_addr,
   output dtlb_pkg::flags_t        ptw_pagetab_flags,
   output dtlb_pkg::flags_t        ptw_pagedir_flags,
   output logic                    ptw_ready
);

   import dtlb_pkg::*;

   integer seed;

   initial begin
      int            delay;
      vpn_t          addr;
      pagedir_base_t base;

      seed = seed_init;
      ptw_ready = 1'b0;
      ptw_phys_addr = '0;
      ptw_pagetab_flags = '0;
      ptw_pagedir_flags = '0;
      forever begin
         @(posedge dtlb_clk);
         #1;
         if (ptw_re) begin
            addr = ptw_addr;
            base = ptw_pagedir_base;
            // Walk takes 1 to 4 cycles
            delay = 1 + ($unsigned($random(seed)) % 4);
            repeat (delay) @(posedge dtlb_clk);
            #1;
            // Page is the address with its halves swapped, mixed with the base
            ptw_phys_addr = {addr[9:0], addr[19:10]} ^ base;
            ptw_pagetab_flags = addr[3:0] ^ addr[11:8];
            ptw_pagedir_flags = base[3:0] ^ addr[19:16];
            ptw_ready = 1'b1;
            @(posedge dtlb_clk);
            #1;
            ptw_ready = 1'b0;
         end
      end
   end

endmodule

/* test/tb_dtlb.sv */
`timescale 1ns/1ns

module tb_dtlb;

   import dtlb_pkg::*;

   localparam int set_bits = 4;
   localparam int tag_bits = vpn_bits - set_bits;
   localparam int sets = 1 << set_bits;
   localparam int reset_cycles = 8;
   localparam int directed_requests = 14;
   localparam int random_requests = 300;
   localparam int pool_size = 12;
   localparam int cycle_limit = reset_cycles + sets +
                                (directed_requests + random_requests) * 8 + 200;
   localparam pagedir_base_t base_value = 20'h3c0de;

   logic          dtlb_clk;
   logic          rst;
   vpn_t          req_addr;
   logic          req_re;
   pagedir_base_t pagedir_base;
   ppn_t          phys_addr;
   flags_t        flags;
   logic          ready;
   vpn_t          ptw_addr;
   logic          ptw_re;
   pagedir_base_t ptw_pagedir_base;
   ppn_t          ptw_phys_addr;
   flags_t        ptw_pagetab_flags;
   flags_t        ptw_pagedir_flags;
   logic          ptw_ready;

   integer seed;
   int     errors;
   int     walks_seen;
   int     walks_expected;

   // Results the DUT still owes with the oldest at the front
   ppn_t   exp_ppn_q[$];
   flags_t exp_flags_q[$];

   // Two newest tags per set with the newer one at index 0
   logic [tag_bits-1:0] recent_tag [sets][2];
   logic                recent_valid [sets][2];

   vpn_t pool [pool_size];

   dtlb #(
      .set_bits (set_bits)
   ) u_dut (
      .dtlb_clk          (dtlb_clk),
      .rst               (rst),
      .req_addr          (req_addr),
      .req_re            (req_re),
      .pagedir_base      (pagedir_base),
      .phys_addr         (phys_addr),
      .flags             (flags),
      .ready             (ready),
      .ptw_addr          (ptw_addr),
      .ptw_re            (ptw_re),
      .ptw_pagedir_base  (ptw_pagedir_base),
      .ptw_phys_addr     (ptw_phys_addr),
      .ptw_pagetab_flags (ptw_pagetab_flags),
      .ptw_pagedir_flags (ptw_pagedir_flags),
      .ptw_ready         (ptw_ready)
   );

   ptw_model #(
      .seed_init (32'h362c_f5e7)
   ) u_ptw (
      .dtlb_clk          (dtlb_clk),
      .ptw_addr          (ptw_addr),
      .ptw_re            (ptw_re),
      .ptw_pagedir_base  (ptw_pagedir_base),
      .ptw_phys_addr     (ptw_phys_addr),
      .ptw_pagetab_flags (ptw_pagetab_flags),
      .ptw_pagedir_flags (ptw_pagedir_flags),
      .ptw_ready         (ptw_ready)
   );

   initial begin
      dtlb_clk = 1'b0;
      forever #4 dtlb_clk = ~dtlb_clk;
   end

   // Walker translation followed by the two-level flag merge
   function automatic void expected_translation(input vpn_t addr, input pagedir_base_t base,
                                                output ppn_t ppn, output flags_t fl);
      flags_t tab;
      flags_t dir;

      ppn = {addr[9:0], addr[19:10]} ^ base;
      tab = addr[3:0] ^ addr[11:8];
      dir = base[3:0] ^ addr[19:16];
      fl[flag_present] = tab[flag_present] & dir[flag_present];
      fl[flag_writeable] = tab[flag_writeable] & dir[flag_writeable];
      fl[flag_kernel] = tab[flag_kernel] | dir[flag_kernel];
      fl[flag_global] = tab[flag_global] | dir[flag_global];
   endfunction

   // Returns 1 when the tag is one of the two newest of its set
   function automatic logic update_recency(input vpn_t addr);
      int                  s;
      logic [tag_bits-1:0] tag;
      logic                newest;
      logic                older;

      s = int'(addr[set_bits-1:0]);
      tag = addr[vpn_bits-1:set_bits];
      newest = recent_valid[s][0] && (recent_tag[s][0] == tag);
      older = recent_valid[s][1] && (recent_tag[s][1] == tag);
      if (!newest) begin
         recent_tag[s][1] = recent_tag[s][0];
         recent_valid[s][1] = recent_valid[s][0];
         recent_tag[s][0] = tag;
         recent_valid[s][0] = 1'b1;
      end
      return newest | older;
   endfunction

   task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flags(input string name, input flags_t got, input flags_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_vpn(input string name, input vpn_t got, input vpn_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_base(input string name, input pagedir_base_t got,
                             input pagedir_base_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         errors++;
         $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // Called one step after the edge that released reset
   task automatic check_clear_time();
      int low_cycles;

      low_cycles = 0;
      @(negedge dtlb_clk);
      while (!ready && low_cycles < 4 * sets) begin
         if (ptw_re) begin
            errors++;
            $display("walker request raised during the clear sweep at %0t ns", $time);
         end
         low_cycles++;
         @(negedge dtlb_clk);
      end
      check_count("clear cycles", low_cycles, sets);
      @(posedge dtlb_clk);
      #1;
   endtask

   // Hold the request until accepted and then idle for gap cycles
   task automatic send_request(input vpn_t addr, input int gap);
      req_addr = addr;
      req_re = 1'b1;
      @(negedge dtlb_clk);
      while (!ready) begin
         @(negedge dtlb_clk);
      end
      @(posedge dtlb_clk);
      #1;
      if (gap > 0) begin
         req_re = 1'b0;
         repeat (gap) begin
            @(posedge dtlb_clk);
            #1;
         end
      end
   endtask

   task automatic drain_results();
      req_re = 1'b0;
      while (exp_ppn_q.size() > 0) begin
         @(posedge dtlb_clk);
      end
      @(posedge dtlb_clk);
      #1;
   endtask

   // Samples in the middle of the cycle after inputs and outputs settle
   initial begin : compare_results
      ppn_t   p;
      flags_t f;
      logic   check_next;
      logic   exp_hit;
      logic   ptw_re_prev;
      vpn_t   walk_addr;
      vpn_t   last_addr;

      check_next = 1'b0;
      exp_hit = 1'b0;
      ptw_re_prev = 1'b0;
      walk_addr = '0;
      last_addr = '0;
      forever begin
         @(negedge dtlb_clk);
         if (!rst) begin
            if (ptw_re && !ptw_re_prev) begin
               walks_seen++;
               walk_addr = ptw_addr;
               // The walk is for the request accepted last
               check_vpn("ptw_addr", ptw_addr, last_addr);
               check_base("ptw_pagedir_base", ptw_pagedir_base, pagedir_base);
            end else if (ptw_re && ptw_addr !== walk_addr) begin
               errors++;
               $display("walker address changed during a walk at %0t ns", $time);
            end
            ptw_re_prev = ptw_re;
            // A hit answers at once and a miss starts a walk
            if (check_next) begin
               check_level("ready", ready, exp_hit);
               check_level("ptw_re", ptw_re, !exp_hit);
               check_next = 1'b0;
            end
            if (exp_ppn_q.size() > 0 && ready) begin
               check_ppn("phys_addr", phys_addr, exp_ppn_q.pop_front());
               check_flags("flags", flags, exp_flags_q.pop_front());
            end
            if (req_re && ready) begin
               expected_translation(req_addr, pagedir_base, p, f);
               exp_ppn_q.push_back(p);
               exp_flags_q.push_back(f);
               last_addr = req_addr;
               exp_hit = update_recency(req_addr);
               if (!exp_hit) begin
                  walks_expected++;
               end
               check_next = 1'b1;
            end
         end
      end
   end

   initial begin : stimulus
      int i;
      int idx;
      int gap;
      int walks_before;
      int model_before;

      seed = 32'h362c_f5e7;
      errors = 0;
      walks_seen = 0;
      walks_expected = 0;
      rst = 1'b1;
      req_re = 1'b0;
      req_addr = '0;
      pagedir_base = base_value;
      for (i = 0; i < sets; i++) begin
         recent_tag[i][0] = '0;
         recent_tag[i][1] = '0;
         recent_valid[i][0] = 1'b0;
         recent_valid[i][1] = 1'b0;
      end
      // Three tags in each of sets 0 to 3
      for (i = 0; i < pool_size; i++) begin
         pool[i] = {tag_bits'(32'h1000 + i * 32'h0111), set_bits'(i % 4)};
      end

      repeat (reset_cycles) @(posedge dtlb_clk);
      #1;
      rst = 1'b0;
      check_clear_time();

      // Cold misses and then the same pages back to back as hits
      send_request(20'h12340, 1);
      send_request(20'habcd1, 1);
      send_request(20'h0f0f2, 1);
      send_request(20'h55553, 1);
      drain_results();
      walks_before = walks_seen;
      send_request(20'h12340, 0);
      send_request(20'habcd1, 0);
      send_request(20'h0f0f2, 0);
      send_request(20'h55553, 0);
      drain_results();
      check_count("walks on repeated pages", walks_seen - walks_before, 0);

      // Sequence A B A C A B in set 9 where C evicts B
      walks_before = walks_seen;
      model_before = walks_expected;
      send_request(20'h11119, 1);
      send_request(20'h22229, 1);
      send_request(20'h11119, 1);
      send_request(20'h33339, 1);
      send_request(20'h11119, 1);
      send_request(20'h22229, 1);
      drain_results();
      check_count("walks in set 9", walks_seen - walks_before, 4);
      check_count("walks against recency model", walks_seen - walks_before,
                  walks_expected - model_before);

      for (i = 0; i < random_requests; i++) begin
         idx = $unsigned($random(seed)) % pool_size;
         gap = $unsigned($random(seed)) % 3;
         send_request(pool[idx], gap);
      end
      drain_results();
      repeat (4) @(posedge dtlb_clk);
      check_count("walk total", walks_seen, walks_expected);

      $display("errors: %0d, walks: %0d, predicted walks: %0d",
               errors, walks_seen, walks_expected);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      int cycles;

      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge dtlb_clk);
         cycles++;
      end
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d, walks: %0d, predicted walks: %0d",
               errors, walks_seen, walks_expected);
      $display("TESTS FAILED");
      $finish;
   end

endmodule
